// File: verilog.f
csr_pkg.sv
csr_cmd_buffer.sv
csr_bus_bridge.sv
csr_scratch_regs.sv
csr_cycle_counter.sv
csr_subsystem_top.sv
csr_subsystem_assertions.sv
tb_csr_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the register subsystem testbench with Verilator and run it.
# The run counts as passed only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_csr_subsystem -f verilog.f \
  --Mdir "$BUILD_DIR" -o Vtb_csr_subsystem
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

# Keep running after assertion errors so the testbench prints its summary
"./$BUILD_DIR/Vtb_csr_subsystem" +verilator+error+limit+1000 > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "No errors" "$LOG_FILE"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG_FILE"
  exit 1
fi

// File: tb_csr_subsystem.sv
`default_nettype none

// Testbench for the register subsystem
// The bound checker does most of the checking, this top drives the commands
module tb_csr_subsystem
  import csr_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // Commands issued over all tests, used to size the watchdog
  localparam int num_cmds_lp = 31;

  logic                       clk_i;
  logic                       arst_n_i;
  logic [header_width_gc-1:0] cmd_header_i;
  logic [data_width_gc-1:0]   cmd_data_i;
  logic                       cmd_v_i;
  logic                       cmd_last_i;
  logic                       cmd_ready_o;
  logic [header_width_gc-1:0] resp_header_o;
  logic [data_width_gc-1:0]   resp_data_o;
  logic                       resp_v_o;
  logic                       resp_last_o;
  logic                       resp_ready_i;

  logic [31:0]                rng_state = 32'h2a8edf57;
  logic [data_width_gc-1:0]   exp_scratch [4];
  string                      cur_test;
  int                         cycle = 0;
  int                         err_cnt = 0;
  int                         errs_at_start = 0;
  int                         tests_run = 0;
  int                         tests_failed = 0;

  csr_subsystem_top DUT (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .cmd_header_i  (cmd_header_i),
    .cmd_data_i    (cmd_data_i),
    .cmd_v_i       (cmd_v_i),
    .cmd_last_i    (cmd_last_i),
    .cmd_ready_o   (cmd_ready_o),
    .resp_header_o (resp_header_o),
    .resp_data_o   (resp_data_o),
    .resp_v_o      (resp_v_o),
    .resp_last_o   (resp_last_o),
    .resp_ready_i  (resp_ready_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycle <= cycle + 1;
  end

  // Generous bound, each command normally completes in a few cycles
  initial
  begin
    repeat (num_cmds_lp * 200) @(posedge clk_i);
    $display("watchdog expired before all tests finished");
    $display("Errors found");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    hi = next_rand();
    return {hi, next_rand()};
  endfunction

  // Low 2^size bytes are written
  function automatic logic [63:0] byte_mask(input logic [1:0] size);
    return (size == 2'd3) ? '1 : (64'd1 << (8 << size)) - 64'd1;
  endfunction

  function automatic logic [11:0] scratch_addr(input int idx);
    return 12'h100 + 12'(8 * idx);
  endfunction

  task automatic check_value(input logic [63:0] expected, input logic [63:0] actual);
    if (actual !== expected)
    begin
      $display("mismatch %s expected %h actual %h", cur_test, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic start_test(input string name);
    @(negedge clk_i);
    cur_test      = name;
    errs_at_start = err_cnt + DUT.checks.fail_cnt;
  endtask

  task automatic finish_test();
    @(negedge clk_i);
    tests_run++;
    if (err_cnt + DUT.checks.fail_cnt != errs_at_start)
    begin
      tests_failed++;
      $display("test %s failed", cur_test);
    end
    else
    begin
      $display("test %s passed", cur_test);
    end
  endtask

  // One command and its response; hold is the number of cycles of back-pressure
  task automatic run_cmd(
    input  logic [1:0]  msg,
    input  logic [1:0]  size,
    input  logic [11:0] addr,
    input  logic [63:0] data,
    input  int          hold,
    output logic [63:0] rdata
  );
    logic [31:0] r;
    logic [23:0] header;
    logic [23:0] rheader;
    r      = next_rand();
    header = {msg, size, r[7:0], addr};
    @(posedge clk_i);
    cmd_header_i <= header;
    cmd_data_i   <= data;
    cmd_v_i      <= 1'b1;
    cmd_last_i   <= 1'b1;
    resp_ready_i <= (hold == 0);
    @(negedge clk_i);
    while (!cmd_ready_o)
    begin
      @(negedge clk_i);
    end
    // The command is taken on this edge
    @(posedge clk_i);
    cmd_v_i <= 1'b0;
    @(negedge clk_i);
    while (!resp_v_o)
    begin
      @(negedge clk_i);
    end
    rdata   = resp_data_o;
    rheader = resp_header_o;
    check_value(64'(header), 64'(rheader));
    if (hold > 0)
    begin
      repeat (hold)
      begin
        @(negedge clk_i);
        if (!resp_v_o || cmd_ready_o || resp_data_o !== rdata || resp_header_o !== rheader)
        begin
          $display("%s: response moved or buffer freed under back-pressure", cur_test);
          err_cnt++;
        end
      end
      @(posedge clk_i);
      resp_ready_i <= 1'b1;
    end
    // Response handshake
    @(posedge clk_i);
  endtask

  initial
  begin
    logic [63:0] rd;
    logic [63:0] v;
    logic [63:0] c1;
    logic [63:0] c2;
    int          t0;
    cmd_header_i = '0;
    cmd_data_i   = '0;
    cmd_v_i      = 1'b0;
    cmd_last_i   = 1'b0;
    resp_ready_i = 1'b1;
    // Start high so that reset sees a real falling edge
    arst_n_i     = 1'b1;
    #1 arst_n_i  = 1'b0;
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;

    start_test("reset_state");
    if (!cmd_ready_o || resp_v_o)
    begin
      $display("after reset the command side is not ready or a response is pending");
      err_cnt++;
    end
    for (int i = 0; i < 4; i++)
    begin
      exp_scratch[i] = '0;
      run_cmd(e_csr_rd, e_csr_size_8, scratch_addr(i), rand64(), 0, rd);
      check_value(64'd0, rd);
    end
    run_cmd(e_csr_rd, e_csr_size_8, 12'h200, rand64(), 0, rd);
    if (rd > 64'd100)
    begin
      $display("counter read after reset is %0d, which is not small", rd);
      err_cnt++;
    end
    finish_test();

    start_test("full_write_read");
    for (int i = 0; i < 4; i++)
    begin
      exp_scratch[i] = rand64();
      run_cmd(e_csr_wr, e_csr_size_8, scratch_addr(i), exp_scratch[i], 0, rd);
    end
    for (int i = 0; i < 4; i++)
    begin
      run_cmd(e_csr_rd, e_csr_size_8, scratch_addr(i), rand64(), 0, rd);
      check_value(exp_scratch[i], rd);
    end
    finish_test();

    // Sizes 1, 2 and 4 bytes go to registers 1, 2 and 3
    start_test("sized_writes");
    for (int s = 0; s < 3; s++)
    begin
      v = rand64();
      exp_scratch[s+1] = (exp_scratch[s+1] & ~byte_mask(2'(s))) | (v & byte_mask(2'(s)));
      run_cmd(e_csr_uc_wr, 2'(s), scratch_addr(s + 1), v, 0, rd);
      run_cmd(e_csr_uc_rd, e_csr_size_8, scratch_addr(s + 1), rand64(), 0, rd);
      check_value(exp_scratch[s+1], rd);
    end
    finish_test();

    start_test("unmapped");
    run_cmd(e_csr_rd, e_csr_size_8, 12'h104, rand64(), 0, rd);
    check_value(64'd0, rd);
    run_cmd(e_csr_wr, e_csr_size_8, 12'h300, rand64(), 0, rd);
    check_value(64'd0, rd);
    for (int i = 0; i < 4; i++)
    begin
      run_cmd(e_csr_rd, e_csr_size_8, scratch_addr(i), rand64(), 0, rd);
      check_value(exp_scratch[i], rd);
    end
    finish_test();

    start_test("back_pressure");
    exp_scratch[0] = rand64();
    run_cmd(e_csr_wr, e_csr_size_8, scratch_addr(0), exp_scratch[0],
      1 + int'(next_rand() % 8), rd);
    run_cmd(e_csr_rd, e_csr_size_8, scratch_addr(0), rand64(), 1 + int'(next_rand() % 8), rd);
    check_value(exp_scratch[0], rd);
    run_cmd(e_csr_rd, e_csr_size_8, scratch_addr(0), rand64(), 0, rd);
    check_value(exp_scratch[0], rd);
    finish_test();

    // The top bit stays clear so the bound cannot wrap
    start_test("counter");
    v     = rand64();
    v[63] = 1'b0;
    t0    = cycle;
    run_cmd(e_csr_wr, e_csr_size_8, 12'h200, v, 0, rd);
    run_cmd(e_csr_rd, e_csr_size_8, 12'h200, rand64(), 0, c1);
    if (c1 < v || c1 >= v + 64'(cycle - t0))
    begin
      $display("counter read %h is outside the range after writing %h", c1, v);
      err_cnt++;
    end
    run_cmd(e_csr_rd, e_csr_size_8, 12'h200, rand64(), 0, c2);
    if (c2 <= c1)
    begin
      $display("second counter read %h is not above the first read %h", c2, c1);
      err_cnt++;
    end
    finish_test();

    $display("%0d tests run, %0d failed, %0d testbench errors, %0d assertion failures",
      tests_run, tests_failed, err_cnt, DUT.checks.fail_cnt);
    if (tests_failed == 0 && err_cnt == 0 && DUT.checks.fail_cnt == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: csr_subsystem_assertions.sv
`default_nettype none

// Protocol checker for the register subsystem
// It keeps its own shadow copy of the scratch bank and compares read responses with it
module csr_subsystem_assertions
  import csr_pkg::*;
(
  input wire                       clk_i,
  input wire                       arst_n_i,
  input wire [header_width_gc-1:0] cmd_header_i,
  input wire [data_width_gc-1:0]   cmd_data_i,
  input wire                       cmd_v_i,
  input wire                       cmd_last_i,
  input wire                       cmd_ready_o,
  input wire [header_width_gc-1:0] resp_header_o,
  input wire [data_width_gc-1:0]   resp_data_o,
  input wire                       resp_v_o,
  input wire                       resp_last_o,
  input wire                       resp_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [data_width_gc-1:0] shadow_r [4];
  logic [data_width_gc-1:0] shadow_sel;
  logic [data_width_gc-1:0] cmd_mask;
  logic [3:0]               cmd_hit;
  logic [3:0]               resp_hit;
  logic [msg_width_gc-1:0]  cmd_msg;
  logic [msg_width_gc-1:0]  resp_msg;
  logic                     cmd_is_wr;
  logic                     resp_is_wr;
  logic                     resp_is_ctr;
  logic                     accept;
  int                       fail_cnt = 0;

  // A size code n writes the low 2^n bytes
  function automatic logic [data_width_gc-1:0] bytes_to_mask(input logic [1:0] size);
    logic [data_width_gc-1:0] mask;
    mask = '1;
    if (size != 2'd3)
    begin
      mask = (64'd1 << (8 << size)) - 64'd1;
    end
    return mask;
  endfunction

  assign accept      = cmd_v_i & cmd_ready_o;
  assign cmd_msg     = cmd_header_i[msg_offset_gc +: msg_width_gc];
  assign resp_msg    = resp_header_o[msg_offset_gc +: msg_width_gc];
  assign cmd_is_wr   = (cmd_msg == e_csr_wr) || (cmd_msg == e_csr_uc_wr);
  assign resp_is_wr  = (resp_msg == e_csr_wr) || (resp_msg == e_csr_uc_wr);
  assign resp_is_ctr = (resp_header_o[11:0] == counter_base_gc);
  assign cmd_mask    = bytes_to_mask(cmd_header_i[size_offset_gc +: size_width_gc]);

  // Scratch registers sit eight bytes apart from the scratch base
  always_comb
  begin
    shadow_sel = '0;
    for (int i = 0; i < 4; i++)
    begin
      cmd_hit[i]  = (cmd_header_i[11:0] == scratch_base_gc + 12'(8 * i));
      resp_hit[i] = (resp_header_o[11:0] == scratch_base_gc + 12'(8 * i));
      if (resp_hit[i])
      begin
        shadow_sel = shadow_r[i];
      end
    end
  end

  // The shadow copy follows accepted writes with the same byte masking
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 0; i < 4; i++)
      begin
        shadow_r[i] <= '0;
      end
    end
    else if (accept && cmd_is_wr)
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (cmd_hit[i])
        begin
          shadow_r[i] <= (shadow_r[i] & ~cmd_mask) | (cmd_data_i & cmd_mask);
        end
      end
    end
  end

  // While reset is held the stream sides are idle
  a_reset_idle: assert property (@(posedge clk_i) !arst_n_i |-> cmd_ready_o && !resp_v_o)
    else begin fail_cnt++; $error("stream not idle during reset"); end

  // Response valid appears exactly two edges after the command is taken
  a_resp_rise: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(resp_v_o) |-> $past(accept, 2))
    else begin fail_cnt++; $error("response valid rose at the wrong time"); end

  a_resp_due: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $past(accept, 2) |-> resp_v_o)
    else begin fail_cnt++; $error("response missing two cycles after a command"); end

  // Back-pressure holds the whole response
  a_resp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_v_o && !resp_ready_i |=>
      resp_v_o && $stable(resp_header_o) && $stable(resp_data_o))
    else begin fail_cnt++; $error("response changed under back-pressure"); end

  a_one_in_flight: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_v_o |-> !cmd_ready_o)
    else begin fail_cnt++; $error("command side ready while a response is pending"); end

  a_last: assert property (@(posedge clk_i) disable iff (!arst_n_i) resp_last_o == resp_v_o)
    else begin fail_cnt++; $error("response last flag differs from response valid"); end

  a_single_beat: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_v_i |-> cmd_last_i)
    else begin fail_cnt++; $error("command without the last flag"); end

  a_scratch_read: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_v_o && !resp_is_wr && (|resp_hit) |-> resp_data_o == shadow_sel)
    else begin fail_cnt++; $error("scratch read differs from shadow copy"); end

  // Writes and unmapped reads answer with zero data
  a_zero_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_v_o && (resp_is_wr || (!(|resp_hit) && !resp_is_ctr)) |-> resp_data_o == '0)
    else begin fail_cnt++; $error("nonzero data on a write or unmapped response"); end

endmodule

bind csr_subsystem_top csr_subsystem_assertions checks (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .cmd_header_i  (cmd_header_i),
  .cmd_data_i    (cmd_data_i),
  .cmd_v_i       (cmd_v_i),
  .cmd_last_i    (cmd_last_i),
  .cmd_ready_o   (cmd_ready_o),
  .resp_header_o (resp_header_o),
  .resp_data_o   (resp_data_o),
  .resp_v_o      (resp_v_o),
  .resp_last_o   (resp_last_o),
  .resp_ready_i  (resp_ready_i)
);

`default_nettype wire

// File: csr_subsystem_top.sv
`default_nettype none

// Register subsystem with four scratch registers and a cycle counter
module csr_subsystem_top
  import csr_pkg::*;
#(
  parameter int scratch_els_p = 4
)
(
  input  wire                        clk_i,
  input  wire                        arst_n_i,

  input  wire  [header_width_gc-1:0] cmd_header_i,
  input  wire  [data_width_gc-1:0]   cmd_data_i,
  input  wire                        cmd_v_i,
  input  wire                        cmd_last_i,
  output logic                       cmd_ready_o,

  output logic [header_width_gc-1:0] resp_header_o,
  output logic [data_width_gc-1:0]   resp_data_o,
  output logic                       resp_v_o,
  output logic                       resp_last_o,
  input  wire                        resp_ready_i
);

  // Scratch registers take the low strobe bits and the counter takes the top one
  localparam int els_lp = scratch_els_p + 1;

  // Scratch bases are spaced by the stride and the counter comes last
  function automatic logic [els_lp-1:0][reg_addr_width_gc-1:0] build_base_addr();
    logic [els_lp-1:0][reg_addr_width_gc-1:0] addrs;
    for (int i = 0; i < scratch_els_p; i++)
    begin
      addrs[i] = scratch_base_gc + reg_addr_width_gc'(i) * scratch_stride_gc;
    end
    addrs[els_lp-1] = counter_base_gc;
    return addrs;
  endfunction

  localparam logic [els_lp-1:0][reg_addr_width_gc-1:0] base_addr_lp = build_base_addr();

  logic [els_lp-1:0]                    reg_r_v;
  logic [els_lp-1:0]                    reg_w_v;
  logic [size_width_gc-1:0]             reg_size;
  logic [data_width_gc-1:0]             reg_wdata;
  logic [els_lp-1:0][data_width_gc-1:0] reg_rdata;

  // Each register has its own strobe, so neither module needs the address
  csr_bus_bridge #(
    .els_p       (els_lp),
    .base_addr_p (base_addr_lp)
  ) bridge (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .cmd_header_i  (cmd_header_i),
    .cmd_data_i    (cmd_data_i),
    .cmd_v_i       (cmd_v_i),
    .cmd_last_i    (cmd_last_i),
    .cmd_ready_o   (cmd_ready_o),
    .resp_header_o (resp_header_o),
    .resp_data_o   (resp_data_o),
    .resp_v_o      (resp_v_o),
    .resp_last_o   (resp_last_o),
    .resp_ready_i  (resp_ready_i),
    .r_v_o         (reg_r_v),
    .w_v_o         (reg_w_v),
    .addr_o        (),
    .size_o        (reg_size),
    .wdata_o       (reg_wdata),
    .rdata_i       (reg_rdata)
  );

  csr_scratch_regs #(
    .scratch_els_p (scratch_els_p)
  ) scratch (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .r_v_i    (reg_r_v[scratch_els_p-1:0]),
    .w_v_i    (reg_w_v[scratch_els_p-1:0]),
    .size_i   (reg_size),
    .wdata_i  (reg_wdata),
    .rdata_o  (reg_rdata[scratch_els_p-1:0])
  );

  csr_cycle_counter counter (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .r_v_i    (reg_r_v[els_lp-1]),
    .w_v_i    (reg_w_v[els_lp-1]),
    .size_i   (reg_size),
    .wdata_i  (reg_wdata),
    .rdata_o  (reg_rdata[els_lp-1])
  );

endmodule

`default_nettype wire

// File: csr_cycle_counter.sv
`default_nettype none

// Free-running cycle counter that can also be loaded
module csr_cycle_counter
  import csr_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      arst_n_i,

  // Single strobe bits from the bridge
  input  wire                      r_v_i,
  input  wire                      w_v_i,
  input  wire  [size_width_gc-1:0] size_i,
  input  wire  [data_width_gc-1:0] wdata_i,

  // Count captured by the last read strobe
  output logic [data_width_gc-1:0] rdata_o
);

  logic [data_width_gc-1:0] count_r;
  logic [data_width_gc-1:0] rdata_r;
  logic [data_width_gc-1:0] wmask;

  // Sized writes keep the upper bytes of the current count
  assign wmask = csr_size_mask(size_i);

  // A write takes the place of that cycle's increment
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      count_r <= '0;
    end
    else if (w_v_i)
    begin
      count_r <= (count_r & ~wmask) | (wdata_i & wmask);
    end
    else
    begin
      count_r <= count_r + 1'b1;
    end
  end

  // Read data holds until the next read strobe
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rdata_r <= '0;
    end
    else if (r_v_i)
    begin
      rdata_r <= count_r;
    end
  end

  assign rdata_o = rdata_r;

endmodule

`default_nettype wire

// File: csr_scratch_regs.sv
`default_nettype none

// Bank of general purpose read/write registers
// Each register has its own strobes and its own read data register
module csr_scratch_regs
  import csr_pkg::*;
#(
  parameter int scratch_els_p = 4
)
(
  input  wire                                          clk_i,
  input  wire                                          arst_n_i,

  // One-hot strobes from the bridge, at most one bit set per cycle
  input  wire  [scratch_els_p-1:0]                     r_v_i,
  input  wire  [scratch_els_p-1:0]                     w_v_i,
  input  wire  [size_width_gc-1:0]                     size_i,
  input  wire  [data_width_gc-1:0]                     wdata_i,

  // Read data holds the value latched by the last read strobe
  output logic [scratch_els_p-1:0][data_width_gc-1:0]  rdata_o
);

  logic [data_width_gc-1:0] wmask;
  logic [data_width_gc-1:0] wmerge_n [scratch_els_p];

  // All registers share the byte mask of the current command
  assign wmask = csr_size_mask(size_i);

  for (genvar i = 0; i < scratch_els_p; i++)
  begin : g_reg
    logic [data_width_gc-1:0] val_r;
    logic [data_width_gc-1:0] rdata_r;

    // Only the low 2^size bytes take the new data
    assign wmerge_n[i] = (val_r & ~wmask) | (wdata_i & wmask);

    // Register contents are part of the visible state and clear on reset
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
      begin
        val_r <= '0;
      end
      else if (w_v_i[i])
      begin
        val_r <= wmerge_n[i];
      end
    end

    // A read strobe captures the full register value
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
      begin
        rdata_r <= '0;
      end
      else if (r_v_i[i])
      begin
        rdata_r <= val_r;
      end
    end

    assign rdata_o[i] = rdata_r;
  end

endmodule

`default_nettype wire

// File: csr_bus_bridge.sv
`default_nettype none

// Bridge from the command/response stream to per-register strobes
// Registers are synchronous and hold their last read value, so the
// response is formed one cycle after the strobe from a registered mask
module csr_bus_bridge
  import csr_pkg::*;
#(
  parameter int els_p = 1,
  parameter logic [els_p-1:0][reg_addr_width_gc-1:0] base_addr_p = '0
)
(
  input  wire                                  clk_i,
  input  wire                                  arst_n_i,

  // Command stream from the network side
  input  wire  [header_width_gc-1:0]           cmd_header_i,
  input  wire  [data_width_gc-1:0]             cmd_data_i,
  input  wire                                  cmd_v_i,
  input  wire                                  cmd_last_i,
  output logic                                 cmd_ready_o,

  // Response stream back to the network side
  output logic [header_width_gc-1:0]           resp_header_o,
  output logic [data_width_gc-1:0]             resp_data_o,
  output logic                                 resp_v_o,
  output logic                                 resp_last_o,
  input  wire                                  resp_ready_i,

  // Register side, one-hot strobes and shared address, size and data
  output logic [els_p-1:0]                     r_v_o,
  output logic [els_p-1:0]                     w_v_o,
  output logic [reg_addr_width_gc-1:0]         addr_o,
  output logic [size_width_gc-1:0]             size_o,
  output logic [data_width_gc-1:0]             wdata_o,
  input  wire  [els_p-1:0][data_width_gc-1:0]  rdata_i
);

  logic [header_width_gc-1:0]   buf_header;
  logic [data_width_gc-1:0]     buf_data;
  logic                         buf_v;
  logic                         buf_yumi;
  logic                         pending_r;
  logic [els_p-1:0]             r_mask_r;
  csr_msg_e                     msg_type;
  logic [reg_addr_width_gc-1:0] reg_addr;
  logic                         wr_not_rd;
  logic                         rd_not_wr;
  logic                         issue;
  logic [data_width_gc-1:0]     rdata_sel;

  // Commands are single beat, cmd_last_i is only observed by the checker
  csr_cmd_buffer cmd_buf (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .header_i (cmd_header_i),
    .data_i   (cmd_data_i),
    .v_i      (cmd_v_i),
    .ready_o  (cmd_ready_o),
    .header_o (buf_header),
    .data_o   (buf_data),
    .v_o      (buf_v),
    .yumi_i   (buf_yumi)
  );

  // Pull the header fields out of the buffered command
  assign msg_type = csr_msg_e'(buf_header[msg_offset_gc +: msg_width_gc]);
  assign reg_addr = buf_header[addr_offset_gc +: reg_addr_width_gc];

  // Uncached types behave like their cached counterparts
  assign wr_not_rd = msg_type inside {e_csr_wr, e_csr_uc_wr};
  assign rd_not_wr = msg_type inside {e_csr_rd, e_csr_uc_rd};

  // A strobe fires once, in the first cycle the command is buffered
  assign issue = buf_v & ~pending_r;

  for (genvar i = 0; i < els_p; i++)
  begin : g_dec
    logic addr_match;
    assign addr_match = (reg_addr == base_addr_p[i]);
    assign r_v_o[i]   = issue & addr_match & rd_not_wr;
    assign w_v_o[i]   = issue & addr_match & wr_not_rd;
  end

  // Pending is set even when nothing matched, so every command
  // is answered and the stream cannot stall
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      pending_r <= 1'b0;
      r_mask_r  <= '0;
    end
    else if (buf_yumi)
    begin
      pending_r <= 1'b0;
      r_mask_r  <= '0;
    end
    else if (issue)
    begin
      pending_r <= 1'b1;
      r_mask_r  <= r_v_o;
    end
  end

  // An empty mask gives zero data for writes and unmapped reads
  always_comb
  begin
    rdata_sel = '0;
    for (int i = 0; i < els_p; i++)
    begin
      if (r_mask_r[i])
      begin
        rdata_sel = rdata_sel | rdata_i[i];
      end
    end
  end

  assign addr_o  = reg_addr;
  assign size_o  = buf_header[size_offset_gc +: size_width_gc];
  assign wdata_o = buf_data;

  // The response echoes the command header
  assign resp_header_o = buf_header;
  assign resp_data_o   = rdata_sel;
  assign resp_v_o      = pending_r;
  assign resp_last_o   = pending_r;

  // The response handshake also frees the command buffer
  assign buf_yumi = pending_r & resp_ready_i;

endmodule

`default_nettype wire

// File: csr_cmd_buffer.sv
`default_nettype none

// Single-entry command buffer holding one header and one data word
module csr_cmd_buffer
  import csr_pkg::*;
(
  input  wire                        clk_i,
  input  wire                        arst_n_i,

  // Enqueue side, a beat is taken when v_i and ready_o are both high
  input  wire  [header_width_gc-1:0] header_i,
  input  wire  [data_width_gc-1:0]   data_i,
  input  wire                        v_i,
  output logic                       ready_o,

  // Dequeue side, yumi_i is only raised while v_o is high
  output logic [header_width_gc-1:0] header_o,
  output logic [data_width_gc-1:0]   data_o,
  output logic                       v_o,
  input  wire                        yumi_i
);

  logic                       full_r;
  logic                       enq;
  logic [header_width_gc-1:0] header_r;
  logic [data_width_gc-1:0]   data_r;

  // The buffer accepts a beat only while it is empty
  assign ready_o = ~full_r;
  assign enq     = v_i & ready_o;

  // Full/empty state is the only control state here
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      full_r <= 1'b0;
    end
    else if (enq)
    begin
      full_r <= 1'b1;
    end
    else if (yumi_i)
    begin
      full_r <= 1'b0;
    end
  end

  // Payload is written on enqueue and held until the next one
  always_ff @(posedge clk_i)
  begin
    if (enq)
    begin
      header_r <= header_i;
      data_r   <= data_i;
    end
  end

  assign v_o      = full_r;
  assign header_o = header_r;
  assign data_o   = data_r;

endmodule

`default_nettype wire

// File: csr_pkg.sv
`default_nettype none

package csr_pkg;

  // Data path and register width in bits
  localparam int data_width_gc = 64;

  // Physical address width carried in the command header
  localparam int paddr_width_gc = 20;

  // Only the low address bits take part in the register decode
  localparam int reg_addr_width_gc = 12;

  // Widths of the remaining header fields
  localparam int msg_width_gc  = 2;
  localparam int size_width_gc = 2;

  // Header layout from LSB upward is addr, then size, then msg_type
  localparam int addr_offset_gc  = 0;
  localparam int size_offset_gc  = addr_offset_gc + paddr_width_gc;
  localparam int msg_offset_gc   = size_offset_gc + size_width_gc;
  localparam int header_width_gc = msg_offset_gc + msg_width_gc;

  // Message types; the uncached forms decode exactly like the plain ones
  typedef enum logic [msg_width_gc-1:0] {
    e_csr_rd    = 2'b00,
    e_csr_wr    = 2'b01,
    e_csr_uc_rd = 2'b10,
    e_csr_uc_wr = 2'b11
  } csr_msg_e;

  // Size codes give the number of bytes written, as 2^size
  typedef enum logic [size_width_gc-1:0] {
    e_csr_size_1 = 2'b00,
    e_csr_size_2 = 2'b01,
    e_csr_size_4 = 2'b10,
    e_csr_size_8 = 2'b11
  } csr_size_e;

  // Default register map, scratch registers sit one dword apart
  localparam logic [reg_addr_width_gc-1:0] scratch_base_gc   = 12'h100;
  localparam logic [reg_addr_width_gc-1:0] scratch_stride_gc = 12'h008;
  localparam logic [reg_addr_width_gc-1:0] counter_base_gc   = 12'h200;

  // Byte mask covering the low 2^size bytes of a register
  function automatic logic [data_width_gc-1:0] csr_size_mask(
    input logic [size_width_gc-1:0] size
  );
    logic [data_width_gc-1:0] mask;
    case (size)
      e_csr_size_1: mask = 64'h0000_0000_0000_00ff;
      e_csr_size_2: mask = 64'h0000_0000_0000_ffff;
      e_csr_size_4: mask = 64'h0000_0000_ffff_ffff;
      default:      mask = '1;
    endcase
    return mask;
  endfunction

endpackage

`default_nettype wire
